//--- Bender.yml
package:
  name: eeprom_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/eeprom_pkg.sv
      - source/i2c_byte_if.sv
      - source/i2c_byte_engine.sv
      - source/eeprom_ctrl.sv
      - source/eeprom_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/clk_gen.sv
      - test/eeprom_model.sv
      - test/tb_eeprom_top.sv

//--- compile.f
+incdir+include
source/eeprom_pkg.sv
source/i2c_byte_if.sv
source/i2c_byte_engine.sv
source/eeprom_ctrl.sv
source/eeprom_top.sv
test/clk_gen.sv
test/eeprom_model.sv
test/tb_eeprom_top.sv

//--- include/eeprom_cfg.svh
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// byte address and data widths
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

// device type code, upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per scl half period
`define SCL_HALF 4

`endif

//--- source/eeprom_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_cfg.svh"

module eeprom_ctrl import eeprom_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req,
    input  eeprom_op_e                op,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wdata,
    output logic                      ack,
    output logic [`EEPROM_DATA_W-1:0] rdata,
    output logic                      err,
    i2c_byte_if.master                bus
);

    ctrl_state_e               state;
    ctrl_state_e               next_state;
    eeprom_op_e                op_q;
    logic [`EEPROM_ADDR_W-1:0] addr_q;
    logic [`EEPROM_DATA_W-1:0] wdata_q;
    logic [`EEPROM_DATA_W-1:0] ctrl_wr;
    logic [`EEPROM_DATA_W-1:0] ctrl_rd;
    logic                      in_cmd;
    logic                      wr_nack;

    // block bits of the address ride in the control byte
    assign ctrl_wr = {`EEPROM_DEV_CODE, addr_q[`EEPROM_ADDR_W-1:`EEPROM_DATA_W], 1'b0};
    assign ctrl_rd = {`EEPROM_DEV_CODE, addr_q[`EEPROM_ADDR_W-1:`EEPROM_DATA_W], 1'b1};

    assign in_cmd  = !(state inside {ST_IDLE, ST_ACK});
    assign wr_nack = bus.nack && (bus.cmd == CMD_WRITE);

    always_comb
    begin
        bus.cmd     = CMD_WRITE;
        bus.tx_byte = ctrl_wr;
        case (state)
            ST_START, ST_RESTART: bus.cmd = CMD_START;
            ST_STOP:              bus.cmd = CMD_STOP;
            ST_ADDR:              bus.tx_byte = addr_q[`EEPROM_DATA_W-1:0];
            ST_DATA_WR:           bus.tx_byte = wdata_q;
            ST_CTRL_RD:           bus.tx_byte = ctrl_rd;
            ST_DATA_RD:           bus.cmd = CMD_READ;
            default:              bus.tx_byte = ctrl_wr;
        endcase
    end

    always_comb
    begin
        case (state)
            ST_START:   next_state = ST_CTRL_WR;
            ST_CTRL_WR: next_state = ST_ADDR;
            ST_ADDR:    next_state = (op_q == OP_READ) ? ST_RESTART : ST_DATA_WR;
            ST_DATA_WR: next_state = ST_STOP;
            ST_RESTART: next_state = ST_CTRL_RD;
            ST_CTRL_RD: next_state = ST_DATA_RD;
            ST_DATA_RD: next_state = ST_STOP;
            ST_STOP:    next_state = ST_ACK;
            default:    next_state = ST_IDLE;
        endcase
        if (wr_nack)
            next_state = ST_STOP;  // abort and skip the remaining bytes
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= ST_IDLE;
            ack         <= 1'b0;
            err         <= 1'b0;
            bus.cmd_req <= 1'b0;
        end
        else
        begin
            if (in_cmd && !bus.cmd_req)
                bus.cmd_req <= 1'b1;
            case (state)
                ST_IDLE:
                begin
                    if (req)
                    begin
                        err   <= 1'b0;
                        state <= ST_START;
                    end
                end
                ST_ACK:
                begin
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    if (bus.done)
                    begin
                        bus.cmd_req <= 1'b0;
                        state       <= next_state;
                        if (wr_nack)
                            err <= 1'b1;
                        if (state == ST_STOP)
                            ack <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && req)
        begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == ST_DATA_RD && bus.done)
            rdata <= bus.rx_byte;
    end

    a_ack_needs_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack) |-> req);

    // done only answers a request that is still held
    a_done_answers_req: assert property (@(posedge CLK) disable iff (RESET)
        bus.done |-> bus.cmd_req);

endmodule

//--- source/eeprom_pkg.sv
package eeprom_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // start doubles as repeated start
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } byte_cmd_e;

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_CTRL_WR, ST_ADDR, ST_DATA_WR,
        ST_RESTART, ST_CTRL_RD, ST_DATA_RD, ST_STOP, ST_ACK
    } ctrl_state_e;

    typedef enum logic [2:0] {
        E_IDLE, E_START, E_STOP, E_SHIFT, E_ACKBIT
    } engine_state_e;

endpackage

//--- source/eeprom_top.sv
`timescale 1ns/1ps
`include "eeprom_cfg.svh"

module eeprom_top import eeprom_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req,
    input  eeprom_op_e                op,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wdata,
    output logic                      ack,
    output logic [`EEPROM_DATA_W-1:0] rdata,
    output logic                      err,
    output logic                      scl,
    inout  wire                       sda
);

    i2c_byte_if bus ();

    eeprom_ctrl i_ctrl (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .err   (err),
        .bus   (bus.master)
    );

    i2c_byte_engine i_engine (
        .CLK   (CLK),
        .RESET (RESET),
        .scl   (scl),
        .sda   (sda),
        .bus   (bus.engine)
    );

endmodule

//--- source/i2c_byte_engine.sv
`timescale 1ns/1ps
`include "eeprom_cfg.svh"

module i2c_byte_engine import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    output logic       scl,
    inout  wire        sda,
    i2c_byte_if.engine bus
);

    localparam int CNT_W = $clog2(2 * `SCL_HALF);
    localparam int BIT_W = $clog2(`EEPROM_DATA_W);

    // points within one scl period starting with the low half
    localparam logic [CNT_W-1:0] CNT_SET  = '0;
    localparam logic [CNT_W-1:0] CNT_RISE = CNT_W'(`SCL_HALF - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(`SCL_HALF + `SCL_HALF / 2 - 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(2 * `SCL_HALF - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`EEPROM_DATA_W - 1);

    engine_state_e             state;
    logic [CNT_W-1:0]          cnt;
    logic [BIT_W-1:0]          bit_cnt;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic                      is_read;
    logic                      sda_low;
    logic                      accept;

    assign sda = sda_low ? 1'b0 : 1'bz;  // open drain
    assign bus.rx_byte = shreg;

    // cmd_req is still up in the done cycle
    assign accept = (state == E_IDLE) && bus.cmd_req && !bus.done;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= E_IDLE;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            cnt      <= '0;
            bit_cnt  <= '0;
            is_read  <= 1'b0;
            bus.done <= 1'b0;
            bus.nack <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            case (state)
                E_IDLE:
                begin
                    if (accept)
                    begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        scl     <= 1'b0;
                        is_read <= (bus.cmd == CMD_READ);
                        case (bus.cmd)
                            CMD_START: state <= E_START;
                            CMD_STOP:  state <= E_STOP;
                            default:   state <= E_SHIFT;
                        endcase
                    end
                end
                E_START, E_STOP:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_SET)
                        sda_low <= (state == E_STOP);   // prepare level while scl low
                    if (cnt == CNT_RISE)
                        scl <= 1'b1;
                    if (cnt == CNT_MID)
                        sda_low <= (state == E_START);  // the edge itself while scl high
                    if (cnt == CNT_LAST)
                    begin
                        cnt      <= '0;
                        bus.done <= 1'b1;
                        state    <= E_IDLE;
                    end
                end
                E_SHIFT:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_SET)
                        sda_low <= !is_read && !shreg[`EEPROM_DATA_W-1];
                    if (cnt == CNT_RISE)
                        scl <= 1'b1;
                    if (cnt == CNT_LAST)
                    begin
                        cnt     <= '0;
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST)
                        begin
                            bit_cnt <= '0;
                            state   <= E_ACKBIT;
                        end
                    end
                end
                E_ACKBIT:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_SET)
                        sda_low <= 1'b0;  // slave acks or master nacks a read
                    if (cnt == CNT_RISE)
                    begin
                        scl      <= 1'b1;
                        bus.nack <= !is_read && sda;
                    end
                    if (cnt == CNT_LAST)
                    begin
                        cnt      <= '0;
                        bus.done <= 1'b1;
                        state    <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // tx byte shifts out msb first while read bits shift in
    always_ff @(posedge CLK)
    begin
        if (accept)
            shreg <= bus.tx_byte;
        else if (state == E_SHIFT && cnt == CNT_RISE)
            shreg <= {shreg[`EEPROM_DATA_W-2:0], sda};
    end

    a_sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        $past(scl) && !($past(state) inside {E_START, E_STOP}) |-> $stable(sda_low));

    // request must be gone before the engine could take it again
    a_done_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        bus.done |=> !bus.done && !bus.cmd_req);

endmodule

//--- source/i2c_byte_if.sv
`timescale 1ns/1ps
`include "eeprom_cfg.svh"

interface i2c_byte_if import eeprom_pkg::*; ();

    logic                      cmd_req;  // held until done
    byte_cmd_e                 cmd;
    logic [`EEPROM_DATA_W-1:0] tx_byte;
    logic                      done;     // one cycle
    logic [`EEPROM_DATA_W-1:0] rx_byte;
    logic                      nack;     // high = no slave ack

    modport master (
        output cmd_req, cmd, tx_byte,
        input  done, rx_byte, nack
    );

    modport engine (
        input  cmd_req, cmd, tx_byte,
        output done, rx_byte, nack
    );

endinterface

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns period
    end

    initial
    begin
        RESET = 1'b1;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
    end

endmodule

//--- test/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_cfg.svh"

module eeprom_model
(
    input  logic scl,
    inout  wire  sda,
    input  logic present
);

    localparam int BLK_W = `EEPROM_ADDR_W - `EEPROM_DATA_W;

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA} model_state_e;

    logic [`EEPROM_DATA_W-1:0] mem [0:(1 << `EEPROM_ADDR_W)-1];
    model_state_e              mstate = M_IDLE;
    int                        bit_cnt = 0;
    logic [`EEPROM_DATA_W-1:0] shreg = '0;
    logic [`EEPROM_DATA_W-1:0] rbyte = '0;
    logic [`EEPROM_DATA_W-1:0] word = '0;
    logic [BLK_W-1:0]          blk = '0;
    logic                      rw = 1'b0;
    logic                      acked = 1'b0;
    logic                      sda_low = 1'b0;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            mem[i] = 8'hff;  // erased state
    end

    // start and stop are sda edges while scl is high
    always @(negedge sda)
        if (scl === 1'b1)
        begin
            mstate  = M_CTRL;
            bit_cnt = 0;
        end

    always @(posedge sda)
        if (scl === 1'b1)
        begin
            mstate  = M_IDLE;
            sda_low = 1'b0;
        end

    always @(posedge scl)
    begin
        if (mstate != M_IDLE)
        begin
            if (bit_cnt < 8)
            begin
                shreg   = {shreg[`EEPROM_DATA_W-2:0], sda};
                bit_cnt = bit_cnt + 1;
            end
            else if (bit_cnt == 8)
                bit_cnt = 9;  // ack slot clocked
        end
    end

    // slave drives only while scl is low
    always @(negedge scl)
    begin
        if (mstate == M_RDATA && bit_cnt > 0 && bit_cnt < 8)
            sda_low = !rbyte[`EEPROM_DATA_W-1-bit_cnt];
        else if (mstate != M_IDLE && bit_cnt == 8)
        begin
            case (mstate)
                M_CTRL:
                begin
                    rw    = shreg[0];
                    blk   = shreg[BLK_W:1];
                    acked = present && (shreg[7:4] == `EEPROM_DEV_CODE);
                end
                M_ADDR:
                begin
                    word  = shreg;
                    acked = present;
                end
                M_WDATA:
                begin
                    acked = present;
                    if (present)
                        mem[{blk, word}] = shreg;
                end
                default: acked = 1'b0;  // master nacks the read byte
            endcase
            sda_low = acked;
        end
        else if (mstate != M_IDLE && bit_cnt == 9)
        begin
            sda_low = 1'b0;
            bit_cnt = 0;
            if (!acked)
                mstate = M_IDLE;
            else if (mstate == M_CTRL && rw)
            begin
                mstate  = M_RDATA;
                rbyte   = mem[{blk, word}];
                sda_low = !rbyte[`EEPROM_DATA_W-1];
            end
            else if (mstate == M_CTRL)
                mstate = M_ADDR;
            else if (mstate == M_ADDR)
                mstate = M_WDATA;  // or a repeated start follows
            else
                mstate = M_IDLE;
        end
    end

endmodule

//--- test/tb_eeprom_top.sv
`timescale 1ns/1ps
`include "eeprom_cfg.svh"

module tb_eeprom_top import eeprom_pkg::*; ();

    localparam int NUM_TXNS       = 40;
    // worst case is a read with seven slots of up to nine scl periods plus gaps
    localparam int TXN_CYCLES     = 7 * (9 * 2 * `SCL_HALF + 4);
    localparam int TIMEOUT_CYCLES = NUM_TXNS * TXN_CYCLES;
    localparam int BLK_W          = `EEPROM_ADDR_W - `EEPROM_DATA_W;
    localparam int NUM_BLKS       = 1 << BLK_W;

    logic                      CLK;
    logic                      RESET;
    logic                      req;
    eeprom_op_e                op;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
    logic                      ack;
    logic [`EEPROM_DATA_W-1:0] rdata;
    logic                      err;
    logic                      scl;
    wire                       sda;
    logic                      slave_on;

    logic [`EEPROM_DATA_W-1:0] shadow [0:(1 << `EEPROM_ADDR_W)-1];
    integer                    seed = 32'hac2a;
    int                        hold_max = 8;
    int                        n_issued = 0;
    int                        n_checked = 0;
    int                        cycle_cnt = 0;
    logic                      ack_q = 1'b0;

    // transaction in flight
    string                     exp_name;
    logic                      exp_read;
    logic                      exp_err;
    logic [`EEPROM_DATA_W-1:0] exp_data;

    pullup (sda);

    clk_gen i_clk_gen (.CLK(CLK), .RESET(RESET));

    eeprom_model i_model (.scl(scl), .sda(sda), .present(slave_on));

    eeprom_top i_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .err   (err),
        .scl   (scl),
        .sda   (sda)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [`EEPROM_DATA_W-1:0] exp_val,
                              input logic [`EEPROM_DATA_W-1:0] act_val);
        if (act_val !== exp_val)
            report_failure($sformatf("Fail %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    task automatic check_err(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            report_failure($sformatf("Fail %s: expected err %b, actual %b", name, exp_val, act_val));
    endtask

    // last value written to an address or else the erased value
    function automatic logic [`EEPROM_DATA_W-1:0] expect_read(input logic [`EEPROM_ADDR_W-1:0] a);
        return shadow[a];
    endfunction

    task automatic run_txn(input string name, input eeprom_op_e t_op,
                           input logic [`EEPROM_ADDR_W-1:0] t_addr,
                           input logic [`EEPROM_DATA_W-1:0] t_data);
        int hold;
        hold     = $unsigned($random(seed)) % hold_max;
        exp_name = name;
        exp_read = (t_op == OP_READ);
        exp_err  = !slave_on;
        exp_data = expect_read(t_addr);
        @(posedge CLK);
        req   <= 1'b1;
        op    <= t_op;
        addr  <= t_addr;
        wdata <= t_data;
        n_issued++;
        @(posedge CLK);
        while (!ack)
            @(posedge CLK);
        repeat (hold)
        begin
            @(posedge CLK);
            if (!ack)
                report_failure("ack dropped while req was still high");
        end
        req <= 1'b0;
        @(posedge CLK);
        while (ack)
            @(posedge CLK);
        if (t_op == OP_WRITE && slave_on)
            shadow[t_addr] = t_data;
    endtask

    task automatic write_byte(input string name, input logic [`EEPROM_ADDR_W-1:0] a,
                              input logic [`EEPROM_DATA_W-1:0] d);
        run_txn(name, OP_WRITE, a, d);
    endtask

    task automatic read_byte(input string name, input logic [`EEPROM_ADDR_W-1:0] a);
        run_txn(name, OP_READ, a, '0);
    endtask

    // compare each finished transaction on the rising ack
    always @(posedge CLK)
    begin
        ack_q <= ack;
        if (!RESET && ack === 1'b1 && ack_q !== 1'b1)
        begin
            if (!req)
                report_failure("ack rose while req was low");
            check_err(exp_name, exp_err, err);
            if (exp_read && !exp_err)
                check_data(exp_name, exp_data, rdata);
            n_checked = n_checked + 1;
        end
    end

    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            report_failure($sformatf("timeout, run did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
    end

    initial
    begin
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [`EEPROM_DATA_W-1:0] d;
        logic [`EEPROM_ADDR_W-1:0] addr_list [$];
        req      = 1'b0;
        op       = OP_WRITE;
        addr     = '0;
        wdata    = '0;
        slave_on = 1'b1;
        for (int i = 0; i < (1 << `EEPROM_ADDR_W); i++)
            shadow[i] = 8'hff;
        @(posedge CLK);
        while (RESET)
            @(posedge CLK);

        // nothing written yet
        repeat (2)
        begin
            a = `EEPROM_ADDR_W'($random(seed));
            read_byte("blank read", a);
        end

        // same word in every block so lost block bits alias
        a = `EEPROM_ADDR_W'($random(seed));
        for (int blk = 0; blk < NUM_BLKS; blk++)
        begin
            a[`EEPROM_ADDR_W-1:`EEPROM_DATA_W] = BLK_W'(blk);
            d = `EEPROM_DATA_W'($random(seed));
            d[BLK_W-1:0] = BLK_W'(blk);  // data differs per block
            write_byte($sformatf("block %0d write", blk), a, d);
        end
        for (int blk = 0; blk < NUM_BLKS; blk++)
        begin
            a[`EEPROM_ADDR_W-1:`EEPROM_DATA_W] = BLK_W'(blk);
            read_byte($sformatf("block %0d readback", blk), a);
        end

        repeat (6)
        begin
            a = `EEPROM_ADDR_W'($random(seed));
            d = `EEPROM_DATA_W'($random(seed));
            addr_list.push_back(a);
            write_byte("scatter write", a, d);
        end
        while (addr_list.size() > 0)
            read_byte("scatter read", addr_list.pop_back());  // reverse order
        d = `EEPROM_DATA_W'($random(seed));
        if (d == expect_read(a))
            d = ~d;  // new value must differ
        write_byte("overwrite", a, d);
        read_byte("overwrite readback", a);

        // slave missing so both kinds end with err
        slave_on = 1'b0;
        write_byte("absent write", a, ~d);
        read_byte("absent read", a);
        slave_on = 1'b1;
        read_byte("restored read", a);
        d = `EEPROM_DATA_W'($random(seed));
        write_byte("restored write", a, d);
        read_byte("restored readback", a);

        hold_max = 32;
        a = `EEPROM_ADDR_W'($random(seed));
        d = `EEPROM_DATA_W'($random(seed));
        write_byte("long hold write", a, d);
        read_byte("long hold read", a);

        repeat (4) @(posedge CLK);
        if (n_checked != n_issued)
            report_failure($sformatf("checker saw %0d of %0d transactions",
                                     n_checked, n_issued));
        else
        begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
